// ==== design/isa_pkg.sv ====
/*
 * isa_pkg
 * RV32 integer subset encodings, widths and the ALU function type
 */
package isa_pkg;

    // datapath and register index widths
    localparam int xlen          = 32;
    localparam int reg_idx_width = 5;

    localparam logic [reg_idx_width-1:0] zero_reg = '0;

    // addi x0, x0, 0
    localparam logic [31:0] nop_inst = 32'h0000_0013;
    // wfi, full word match
    localparam logic [31:0] wfi_inst = 32'h1050_0073;

    ////////////////////
    // opcode classes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_system = 7'b1110011;

    ////////////////////
    // funct3 per operation
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_word    = 3'b010;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    // funct7, base ops and sub
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // pass_b forwards operand b, used for the jal link value
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_func_t;

endpackage

// ==== design/pipe_pkg.sv ====
/*
 * pipe_pkg
 * payloads carried between the core stages, bus command and exit status
 */
package pipe_pkg;

    typedef enum logic [1:0] {
        bus_none,
        bus_load,
        bus_store
    } bus_command_t;

    // no_error must stay zero, reset payloads read as no_error
    typedef enum logic [1:0] {
        no_error,
        halted_on_wfi,
        illegal_inst
    } exit_status_t;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne,
        br_jump
    } branch_kind_t;

    typedef struct packed {
        logic [31:0]              inst;
        logic [isa_pkg::xlen-1:0] pc;
        logic [isa_pkg::xlen-1:0] npc;
        logic                     valid;
    } if_id_t;

    typedef struct packed {
        logic [isa_pkg::xlen-1:0]          pc;
        logic [isa_pkg::xlen-1:0]          npc;
        logic [isa_pkg::xlen-1:0]          rs1_value;
        logic [isa_pkg::xlen-1:0]          rs2_value;
        logic [isa_pkg::xlen-1:0]          imm;
        logic                              opa_is_pc;
        logic                              opb_is_imm;
        isa_pkg::alu_func_t                alu_func;
        logic [isa_pkg::reg_idx_width-1:0] dest_idx;
        logic                              rd_mem;
        logic                              wr_mem;
        branch_kind_t                      branch;
        exit_status_t                      status;
        logic                              valid;
    } id_ex_t;

    typedef struct packed {
        logic [isa_pkg::xlen-1:0]          alu_result;
        logic [isa_pkg::xlen-1:0]          rs2_value;
        logic [isa_pkg::xlen-1:0]          npc;
        logic [isa_pkg::reg_idx_width-1:0] dest_idx;
        logic                              rd_mem;
        logic                              wr_mem;
        logic                              take_branch;
        logic [isa_pkg::xlen-1:0]          branch_target;
        exit_status_t                      status;
        logic                              valid;
    } ex_mem_t;

    typedef struct packed {
        logic [isa_pkg::xlen-1:0]          result;
        logic [isa_pkg::xlen-1:0]          npc;
        logic [isa_pkg::reg_idx_width-1:0] dest_idx;
        logic                              wr_en;
        logic                              take_branch;
        logic [isa_pkg::xlen-1:0]          branch_target;
        exit_status_t                      status;
        logic                              valid;
    } mem_wb_t;

endpackage

// ==== design/pipe_reg.sv ====
/*
 * pipe_reg
 * stage register between two core stages, cleared to zero on reset
 */
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t d,
    output payload_t q
);

    // all-zero payload has valid low
    // downstream stages ignore it
    always_ff @(posedge clock) begin
        if (reset) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

// ==== design/fetch_stage.sv ====
/*
 * fetch_stage
 * program counter, one-in-flight fetch throttle and commit-time redirect
 */
module fetch_stage (
    input  logic                     clock,
    input  logic                     reset,
    input  pipe_pkg::mem_wb_t        commit,
    input  logic [isa_pkg::xlen-1:0] fetch_data,
    output logic [isa_pkg::xlen-1:0] fetch_addr,
    output pipe_pkg::if_id_t         fetch_out
);

    logic [isa_pkg::xlen-1:0] pc;
    logic                     fetch_valid;

    // fetch again only after a clean commit
    // halt or illegal leaves fetch_valid low for good
    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_valid <= 1'b1;
            pc          <= '0;
        end else begin
            fetch_valid <= commit.valid && (commit.status == pipe_pkg::no_error);
            // branch decision applied at commit
            if (commit.valid) begin
                pc <= commit.take_branch ? commit.branch_target : commit.npc;
            end
        end
    end

    assign fetch_addr = pc;

    // idle cycles carry a nop word with valid low
    assign fetch_out.inst  = fetch_valid ? fetch_data : isa_pkg::nop_inst;
    assign fetch_out.pc    = pc;
    assign fetch_out.npc   = pc + 32'd4;
    assign fetch_out.valid = fetch_valid;

endmodule

// ==== design/regfile.sv ====
/*
 * regfile
 * 32 x 32-bit integer registers, two read ports, one write port
 */
module regfile (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [isa_pkg::reg_idx_width-1:0] rs1_idx,
    input  logic [isa_pkg::reg_idx_width-1:0] rs2_idx,
    output logic [isa_pkg::xlen-1:0]          rs1_value,
    output logic [isa_pkg::xlen-1:0]          rs2_value,
    input  logic                              wr_en,
    input  logic [isa_pkg::reg_idx_width-1:0] wr_idx,
    input  logic [isa_pkg::xlen-1:0]          wr_data
);

    logic [isa_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wr_en && (wr_idx != isa_pkg::zero_reg)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // x0 always reads zero
    // no write-through, reads never overlap a pending write
    assign rs1_value = (rs1_idx == isa_pkg::zero_reg) ? '0 : regs[rs1_idx];
    assign rs2_value = (rs2_idx == isa_pkg::zero_reg) ? '0 : regs[rs2_idx];

endmodule

// ==== design/decode_stage.sv ====
/*
 * decode_stage
 * instruction decode, immediate build and register operand read
 */
module decode_stage (
    input  logic                              clock,
    input  logic                              reset,
    input  pipe_pkg::if_id_t                  if_id,
    input  logic                              wr_en,
    input  logic [isa_pkg::reg_idx_width-1:0] wr_idx,
    input  logic [isa_pkg::xlen-1:0]          wr_data,
    output pipe_pkg::id_ex_t                  id_out
);

    logic [31:0]              inst;
    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [isa_pkg::xlen-1:0] rs1_value;
    logic [isa_pkg::xlen-1:0] rs2_value;
    logic [isa_pkg::xlen-1:0] imm_i;
    logic [isa_pkg::xlen-1:0] imm_s;
    logic [isa_pkg::xlen-1:0] imm_b;
    logic [isa_pkg::xlen-1:0] imm_j;

    assign inst   = if_id.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    ////////////////////
    // immediates, all sign-extended
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    regfile regfile_0 (
        .clock     (clock),
        .reset     (reset),
        .rs1_idx   (inst[19:15]),
        .rs2_idx   (inst[24:20]),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

    ////////////////////
    // control decode
    always_comb begin
        id_out           = '0;
        id_out.pc        = if_id.pc;
        id_out.npc       = if_id.npc;
        id_out.rs1_value = rs1_value;
        id_out.rs2_value = rs2_value;
        id_out.valid     = if_id.valid;
        id_out.dest_idx  = inst[11:7];
        id_out.alu_func  = isa_pkg::alu_add;
        id_out.branch    = pipe_pkg::br_none;
        id_out.status    = pipe_pkg::no_error;

        case (opcode)
            isa_pkg::opc_op: begin
                case ({funct7, funct3})
                    {isa_pkg::f7_base, isa_pkg::f3_add_sub}: id_out.alu_func = isa_pkg::alu_add;
                    {isa_pkg::f7_sub, isa_pkg::f3_add_sub}:  id_out.alu_func = isa_pkg::alu_sub;
                    {isa_pkg::f7_base, isa_pkg::f3_and}:     id_out.alu_func = isa_pkg::alu_and;
                    {isa_pkg::f7_base, isa_pkg::f3_or}:      id_out.alu_func = isa_pkg::alu_or;
                    {isa_pkg::f7_base, isa_pkg::f3_xor}:     id_out.alu_func = isa_pkg::alu_xor;
                    default: id_out.status = pipe_pkg::illegal_inst;
                endcase
            end
            isa_pkg::opc_op_imm: begin
                // addi only
                id_out.opb_is_imm = 1'b1;
                id_out.imm        = imm_i;
                if (funct3 != isa_pkg::f3_add_sub) begin
                    id_out.status = pipe_pkg::illegal_inst;
                end
            end
            isa_pkg::opc_load: begin
                id_out.opb_is_imm = 1'b1;
                id_out.imm        = imm_i;
                id_out.rd_mem     = (funct3 == isa_pkg::f3_word);
                if (funct3 != isa_pkg::f3_word) begin
                    id_out.status = pipe_pkg::illegal_inst;
                end
            end
            isa_pkg::opc_store: begin
                // address is rs1 + s-imm, data is rs2
                id_out.opb_is_imm = 1'b1;
                id_out.imm        = imm_s;
                id_out.dest_idx   = isa_pkg::zero_reg;
                id_out.wr_mem     = (funct3 == isa_pkg::f3_word);
                if (funct3 != isa_pkg::f3_word) begin
                    id_out.status = pipe_pkg::illegal_inst;
                end
            end
            isa_pkg::opc_branch: begin
                id_out.opa_is_pc = 1'b1;
                id_out.imm       = imm_b;
                id_out.dest_idx  = isa_pkg::zero_reg;
                case (funct3)
                    isa_pkg::f3_beq: id_out.branch = pipe_pkg::br_eq;
                    isa_pkg::f3_bne: id_out.branch = pipe_pkg::br_ne;
                    default:         id_out.status = pipe_pkg::illegal_inst;
                endcase
            end
            isa_pkg::opc_jal: begin
                // link value comes through pass_b
                id_out.opa_is_pc = 1'b1;
                id_out.imm       = imm_j;
                id_out.alu_func  = isa_pkg::alu_pass_b;
                id_out.branch    = pipe_pkg::br_jump;
            end
            isa_pkg::opc_system: begin
                id_out.status = (inst == isa_pkg::wfi_inst) ? pipe_pkg::halted_on_wfi
                                                            : pipe_pkg::illegal_inst;
            end
            default: id_out.status = pipe_pkg::illegal_inst;
        endcase

        // halt and illegal write nothing, touch no memory
        if (id_out.status != pipe_pkg::no_error) begin
            id_out.dest_idx = isa_pkg::zero_reg;
            id_out.rd_mem   = 1'b0;
            id_out.wr_mem   = 1'b0;
            id_out.branch   = pipe_pkg::br_none;
        end
    end

endmodule

// ==== design/execute_stage.sv ====
/*
 * execute_stage
 * operand select, ALU, branch compare and branch target
 */
module execute_stage (
    input  pipe_pkg::id_ex_t  id_ex,
    output pipe_pkg::ex_mem_t ex_out
);

    logic [isa_pkg::xlen-1:0] opa;
    logic [isa_pkg::xlen-1:0] opb;
    logic [isa_pkg::xlen-1:0] alu_result;
    logic                     rs_equal;

    // jal feeds its npc into b for the link value
    assign opa = id_ex.opa_is_pc ? id_ex.pc : id_ex.rs1_value;
    assign opb = (id_ex.branch == pipe_pkg::br_jump) ? id_ex.npc
               : id_ex.opb_is_imm ? id_ex.imm : id_ex.rs2_value;

    always_comb begin
        case (id_ex.alu_func)
            isa_pkg::alu_add:    alu_result = opa + opb;
            isa_pkg::alu_sub:    alu_result = opa - opb;
            isa_pkg::alu_and:    alu_result = opa & opb;
            isa_pkg::alu_or:     alu_result = opa | opb;
            isa_pkg::alu_xor:    alu_result = opa ^ opb;
            isa_pkg::alu_pass_b: alu_result = opb;
            default:             alu_result = '0;
        endcase
    end

    ////////////////////
    // branch resolve
    assign rs_equal = (id_ex.rs1_value == id_ex.rs2_value);

    assign ex_out.take_branch = (id_ex.branch == pipe_pkg::br_jump)
                             || ((id_ex.branch == pipe_pkg::br_eq) && rs_equal)
                             || ((id_ex.branch == pipe_pkg::br_ne) && !rs_equal);
    assign ex_out.branch_target = id_ex.pc + id_ex.imm;

    // pass-through fields
    assign ex_out.alu_result = alu_result;
    assign ex_out.rs2_value  = id_ex.rs2_value;
    assign ex_out.npc        = id_ex.npc;
    assign ex_out.dest_idx   = id_ex.dest_idx;
    assign ex_out.rd_mem     = id_ex.rd_mem;
    assign ex_out.wr_mem     = id_ex.wr_mem;
    assign ex_out.status     = id_ex.status;
    assign ex_out.valid      = id_ex.valid;

endmodule

// ==== design/memory_stage.sv ====
/*
 * memory_stage
 * shared bus owner, load return and writeback fields
 */
module memory_stage (
    input  pipe_pkg::ex_mem_t          ex_mem,
    input  logic [isa_pkg::xlen-1:0]   fetch_addr,
    input  logic [isa_pkg::xlen-1:0]   mem_rdata,
    output pipe_pkg::bus_command_t     mem_command,
    output logic [isa_pkg::xlen-1:0]   mem_addr,
    output logic [isa_pkg::xlen-1:0]   mem_wdata,
    output pipe_pkg::mem_wb_t          mem_out
);

    logic do_load;
    logic do_store;

    assign do_load  = ex_mem.valid && ex_mem.rd_mem;
    assign do_store = ex_mem.valid && ex_mem.wr_mem;

    ////////////////////
    // data access beats fetch
    always_comb begin
        if (do_load) begin
            mem_command = pipe_pkg::bus_load;
            mem_addr    = ex_mem.alu_result;
        end else if (do_store) begin
            mem_command = pipe_pkg::bus_store;
            mem_addr    = ex_mem.alu_result;
        end else begin
            // idle bus carries the instruction fetch
            mem_command = pipe_pkg::bus_load;
            mem_addr    = fetch_addr;
        end
    end

    assign mem_wdata = ex_mem.rs2_value;

    // zero-latency memory, load data lands this cycle
    assign mem_out.result        = ex_mem.rd_mem ? mem_rdata : ex_mem.alu_result;
    assign mem_out.npc           = ex_mem.npc;
    assign mem_out.dest_idx      = ex_mem.dest_idx;
    assign mem_out.wr_en         = ex_mem.valid && (ex_mem.dest_idx != isa_pkg::zero_reg);
    assign mem_out.take_branch   = ex_mem.take_branch;
    assign mem_out.branch_target = ex_mem.branch_target;
    assign mem_out.status        = ex_mem.status;
    assign mem_out.valid         = ex_mem.valid;

endmodule

// ==== design/cpu_core.sv ====
/*
 * cpu_core
 * five-stage RV32 subset core, one instruction in flight,
 * single shared word bus with data ahead of fetch
 */
module cpu_core (
    input  logic                              clock,
    input  logic                              reset,
    output pipe_pkg::bus_command_t            mem_command,
    output logic [isa_pkg::xlen-1:0]          mem_addr,
    output logic [isa_pkg::xlen-1:0]          mem_wdata,
    input  logic [isa_pkg::xlen-1:0]          mem_rdata,
    output logic                              commit_valid,
    output logic                              commit_wr_en,
    output logic [isa_pkg::reg_idx_width-1:0] commit_wr_idx,
    output logic [isa_pkg::xlen-1:0]          commit_wr_data,
    output logic [isa_pkg::xlen-1:0]          commit_npc,
    output pipe_pkg::exit_status_t            exit_status
);

    logic [isa_pkg::xlen-1:0] fetch_addr;

    // stage outputs, _d, and register contents, _q
    pipe_pkg::if_id_t  if_id_d,  if_id_q;
    pipe_pkg::id_ex_t  id_ex_d,  id_ex_q;
    pipe_pkg::ex_mem_t ex_mem_d, ex_mem_q;
    pipe_pkg::mem_wb_t mem_wb_d, mem_wb_q;

    ////////////////////
    // fetch
    fetch_stage fetch_stage_0 (
        .clock      (clock),
        .reset      (reset),
        .commit     (mem_wb_q),
        .fetch_data (mem_rdata),
        .fetch_addr (fetch_addr),
        .fetch_out  (if_id_d)
    );

    pipe_reg #(.payload_t(pipe_pkg::if_id_t)) if_id_reg (
        .clock (clock), .reset (reset), .d (if_id_d), .q (if_id_q)
    );

    ////////////////////
    // decode, written back from mem/wb
    decode_stage decode_stage_0 (
        .clock   (clock),
        .reset   (reset),
        .if_id   (if_id_q),
        .wr_en   (mem_wb_q.wr_en),
        .wr_idx  (mem_wb_q.dest_idx),
        .wr_data (mem_wb_q.result),
        .id_out  (id_ex_d)
    );

    pipe_reg #(.payload_t(pipe_pkg::id_ex_t)) id_ex_reg (
        .clock (clock), .reset (reset), .d (id_ex_d), .q (id_ex_q)
    );

    execute_stage execute_stage_0 (
        .id_ex  (id_ex_q),
        .ex_out (ex_mem_d)
    );

    pipe_reg #(.payload_t(pipe_pkg::ex_mem_t)) ex_mem_reg (
        .clock (clock), .reset (reset), .d (ex_mem_d), .q (ex_mem_q)
    );

    ////////////////////
    // memory, owns the external bus
    memory_stage memory_stage_0 (
        .ex_mem      (ex_mem_q),
        .fetch_addr  (fetch_addr),
        .mem_rdata   (mem_rdata),
        .mem_command (mem_command),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_out     (mem_wb_d)
    );

    pipe_reg #(.payload_t(pipe_pkg::mem_wb_t)) mem_wb_reg (
        .clock (clock), .reset (reset), .d (mem_wb_d), .q (mem_wb_q)
    );

    // commit straight from the writeback register
    assign commit_valid   = mem_wb_q.valid;
    assign commit_wr_en   = mem_wb_q.wr_en;
    assign commit_wr_idx  = mem_wb_q.dest_idx;
    assign commit_wr_data = mem_wb_q.result;
    assign commit_npc     = mem_wb_q.npc;
    assign exit_status    = mem_wb_q.status;

endmodule

// ==== tests/cpu_core_tb.sv ====
/*
 * cpu_core_tb
 * runs two program images on the core and checks every commit
 * against a table of expected writeback values
 */
module cpu_core_tb;

    localparam int num_rows     = 20;
    localparam int num_images   = 2;
    localparam int quiet_cycles = 20;
    localparam int commit_gap   = 5;
    localparam int clock_period = 20;
    // commit budget plus reset and quiet window per image
    localparam int watchdog_time = (num_rows + 4) * commit_gap * clock_period
                                 + num_images * (quiet_cycles + 3) * clock_period;

    typedef struct packed {
        int                             image;
        logic                           wr_en;
        logic [4:0]                     wr_idx;
        logic [31:0]                    wr_data;
        logic                           data_care;
        logic [31:0]                    npc;
        pipe_pkg::exit_status_t         status;
    } commit_row_t;

    logic                   clock;
    logic                   reset;
    logic [31:0]            mem_rdata;
    pipe_pkg::bus_command_t mem_command;
    logic [31:0]            mem_addr;
    logic [31:0]            mem_wdata;
    logic                   commit_valid;
    logic                   commit_wr_en;
    logic [4:0]             commit_wr_idx;
    logic [31:0]            commit_wr_data;
    logic [31:0]            commit_npc;
    pipe_pkg::exit_status_t exit_status;

    logic [31:0] mem [128];
    int          image_sel;
    commit_row_t rows [num_rows];
    int          row_count;
    int          value_errors;
    int          order_errors;

    cpu_core dut (
        .clock          (clock),
        .reset          (reset),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .commit_valid   (commit_valid),
        .commit_wr_en   (commit_wr_en),
        .commit_wr_idx  (commit_wr_idx),
        .commit_wr_data (commit_wr_data),
        .commit_npc     (commit_npc),
        .exit_status    (exit_status)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    ////////////////////
    // instruction encoders
    function automatic logic [31:0] rtype(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, isa_pkg::opc_op};
    endfunction

    function automatic logic [31:0] itype(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, isa_pkg::f3_word, imm[4:0], isa_pkg::opc_store};
    endfunction

    function automatic logic [31:0] btype(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], isa_pkg::opc_branch};
    endfunction

    function automatic logic [31:0] jtype(logic [31:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isa_pkg::opc_jal};
    endfunction

    // program images with unused words holding their own index
    function automatic logic [31:0] image_word(int sel, int idx);
        logic [31:0] w;
        w = 32'hbad0_0000 | idx;
        if (sel == 0) begin
            case (idx)
                0:  w = itype(5, 0, isa_pkg::f3_add_sub, 1, isa_pkg::opc_op_imm);
                1:  w = itype(12, 0, isa_pkg::f3_add_sub, 2, isa_pkg::opc_op_imm);
                2:  w = rtype(isa_pkg::f7_base, 2, 1, isa_pkg::f3_add_sub, 3);
                3:  w = rtype(isa_pkg::f7_sub, 1, 2, isa_pkg::f3_add_sub, 4);
                4:  w = rtype(isa_pkg::f7_base, 2, 1, isa_pkg::f3_and, 5);
                5:  w = rtype(isa_pkg::f7_base, 2, 1, isa_pkg::f3_or, 6);
                6:  w = rtype(isa_pkg::f7_base, 2, 1, isa_pkg::f3_xor, 7);
                7:  w = itype(9, 1, isa_pkg::f3_add_sub, 0, isa_pkg::opc_op_imm);
                8:  w = rtype(isa_pkg::f7_base, 0, 0, isa_pkg::f3_add_sub, 8);
                9:  w = stype(256, 3, 0);
                10: w = itype(256, 0, isa_pkg::f3_word, 9, isa_pkg::opc_load);
                11: w = itype(260, 0, isa_pkg::f3_word, 10, isa_pkg::opc_load);
                // taken beq over word 13 since x3 and x9 both hold 17
                12: w = btype(8, 9, 3, isa_pkg::f3_beq);
                13: w = itype(99, 0, isa_pkg::f3_add_sub, 11, isa_pkg::opc_op_imm);
                14: w = btype(8, 3, 9, isa_pkg::f3_bne);
                15: w = itype(1, 0, isa_pkg::f3_add_sub, 12, isa_pkg::opc_op_imm);
                16: w = jtype(12, 13);
                17: w = itype(7, 0, isa_pkg::f3_add_sub, 14, isa_pkg::opc_op_imm);
                19: w = rtype(isa_pkg::f7_base, 12, 0, isa_pkg::f3_add_sub, 15);
                20: w = isa_pkg::wfi_inst;
                64: w = 32'h1111_1111;
                65: w = 32'hcafe_f00d;
                default: w = 32'hbad0_0000 | idx;
            endcase
        end else begin
            case (idx)
                0:  w = itype(42, 0, isa_pkg::f3_add_sub, 1, isa_pkg::opc_op_imm);
                1:  w = 32'hffff_ffff;
                default: w = 32'hbad0_0000 | idx;
            endcase
        end
        return w;
    endfunction

    ////////////////////
    // memory model reloaded while reset is high
    assign mem_rdata = mem[mem_addr[8:2]];

    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 128; i++) begin
                mem[i] <= image_word(image_sel, i);
            end
        end else if (mem_command == pipe_pkg::bus_store) begin
            mem[mem_addr[8:2]] <= mem_wdata;
        end
    end

    task automatic add_row(int image, logic wr_en, logic [4:0] idx, logic [31:0] data,
                           logic care, logic [31:0] npc, pipe_pkg::exit_status_t status);
        rows[row_count] = '{image, wr_en, idx, data, care, npc, status};
        row_count++;
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        assert (got === expected) else begin
            value_errors++;
            $display("error %0t %s: got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic build_table();
        row_count = 0;
        add_row(0, 1, 1, 5, 1, 4, pipe_pkg::no_error);
        add_row(0, 1, 2, 12, 1, 8, pipe_pkg::no_error);
        add_row(0, 1, 3, 17, 1, 12, pipe_pkg::no_error);
        add_row(0, 1, 4, 7, 1, 16, pipe_pkg::no_error);
        add_row(0, 1, 5, 4, 1, 20, pipe_pkg::no_error);
        add_row(0, 1, 6, 13, 1, 24, pipe_pkg::no_error);
        add_row(0, 1, 7, 9, 1, 28, pipe_pkg::no_error);
        // write to x0 is dropped
        add_row(0, 0, 0, 0, 0, 32, pipe_pkg::no_error);
        add_row(0, 1, 8, 0, 1, 36, pipe_pkg::no_error);
        add_row(0, 0, 0, 0, 0, 40, pipe_pkg::no_error);
        add_row(0, 1, 9, 17, 1, 44, pipe_pkg::no_error);
        add_row(0, 1, 10, 32'hcafe_f00d, 1, 48, pipe_pkg::no_error);
        add_row(0, 0, 0, 0, 0, 52, pipe_pkg::no_error);
        add_row(0, 0, 0, 0, 0, 60, pipe_pkg::no_error);
        add_row(0, 1, 12, 1, 1, 64, pipe_pkg::no_error);
        // jal link is pc + 4
        add_row(0, 1, 13, 68, 1, 68, pipe_pkg::no_error);
        add_row(0, 1, 15, 1, 1, 80, pipe_pkg::no_error);
        add_row(0, 0, 0, 0, 0, 84, pipe_pkg::halted_on_wfi);
        add_row(1, 1, 1, 42, 1, 4, pipe_pkg::no_error);
        add_row(1, 0, 0, 0, 0, 8, pipe_pkg::illegal_inst);
    endtask

    // two reset edges with the new image selected
    task automatic restart(int image);
        @(posedge clock);
        reset     <= 1'b1;
        image_sel <= image;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
    endtask

    initial begin
        #(watchdog_time);
        $display("watchdog expired, commits stopped early");
        $display("sim failed");
        $finish;
    end

    initial begin
        int gap;
        reset        = 1'b1;
        image_sel    = 0;
        value_errors = 0;
        order_errors = 0;
        build_table();

        for (int img = 0; img < num_images; img++) begin
            restart(img);
            for (int r = 0; r < row_count; r++) begin
                if (rows[r].image == img) begin
                    // sample on the falling edge where outputs have settled
                    gap = 0;
                    do begin
                        @(negedge clock);
                        gap++;
                    end while (!commit_valid);
                    check_value("commit gap", gap, commit_gap);
                    check_value("commit_wr_en", commit_wr_en, rows[r].wr_en);
                    check_value("commit_wr_idx", commit_wr_idx, rows[r].wr_idx);
                    if (rows[r].data_care) begin
                        check_value("commit_wr_data", commit_wr_data, rows[r].wr_data);
                    end
                    check_value("commit_npc", commit_npc, rows[r].npc);
                    check_value("exit_status", exit_status, rows[r].status);
                    // idle bus still fetches from the committing pc
                    check_value("mem_command", mem_command, pipe_pkg::bus_load);
                    check_value("mem_addr", mem_addr, rows[r].npc - 32'd4);
                    if (rows[r].status != pipe_pkg::no_error) begin
                        repeat (quiet_cycles) begin
                            @(negedge clock);
                            assert (!commit_valid) else begin
                                order_errors++;
                                $display("a commit appeared at %0t after the core stopped",
                                         $time);
                            end
                        end
                    end
                end
            end
        end

        $display("value errors: %0d, ordering errors: %0d", value_errors, order_errors);
        if (value_errors == 0 && order_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/isa_pkg.sv
design/pipe_pkg.sv
design/pipe_reg.sv
design/fetch_stage.sv
design/regfile.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_core.sv
tests/cpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module cpu_core_tb -o sim_cpu_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_cpu_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "sim passed"; then
    exit 0
fi
exit 1
